/* Makefile */
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = vga_tb
FLIST = verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* include/vga_config.svh */
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// Horizontal timing, shared by both modes
`define HOR_DISP_END 10'd639
`define HOR_SYNC_BEG 10'd655
`define HOR_SYNC_END 10'd751
`define HOR_SCAN_END 10'd799

// 640x400 text mode
`define TXT_DISP_END 10'd400
`define TXT_SYNC_BEG 10'd412
`define TXT_SYNC_END 10'd415
`define TXT_SCAN_END 10'd448

// 640x480 planar mode
`define PLN_DISP_END 10'd480
`define PLN_SYNC_BEG 10'd490
`define PLN_SYNC_END 10'd492
`define PLN_SCAN_END 10'd524

// Word addresses in video memory
`define TEXT_BASE 17'd0
`define FONT_BASE 17'd4096

// Cycles from scan position to renderer output
`define RENDER_DELAY 8

`define MEM_ADR_W 17
`define MEM_DAT_W 16

`endif

/* source/color_mixer.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

module color_mixer (
  input  logic                   clk,
  input  logic                   rst,
  input  vga_pkg::display_mode_e mode_i,
  input  logic                   video_on_v_i,
  input  logic                   vsync_n_i,
  pixel_if.mixer                 text_pix,
  pixel_if.mixer                 pln_pix,
  input  logic                   pal_we_i,
  input  logic [3:0]             pal_addr_i,
  input  logic [7:0]             pal_dat_i,
  input  logic                   dac_we_i,
  input  logic [7:0]             dac_addr_i,
  input  vga_pkg::rgb18_t        dac_dat_i,
  output logic [`MEM_ADR_W-1:0]  mem_adr_o,
  output logic                   mem_stb_o,
  output logic [3:0]             red_o,
  output logic [3:0]             green_o,
  output logic [3:0]             blue_o,
  output logic                   hsync_o,
  output logic                   vsync_o,
  output logic                   v_retrace_o,
  output logic                   vh_retrace_o
);
  import vga_pkg::*;

  localparam int VS_DELAY = `RENDER_DELAY + 3;  // Renderer plus the three stages here

  logic [7:0]          palette [16];
  rgb18_t              dac [256];
  logic                text_sel;
  attr_t               attr_sel;
  logic [7:0]          pal_idx;
  rgb18_t              dac_q;
  logic [2:0]          on_pipe;
  logic [1:0]          hs_pipe;
  logic [VS_DELAY-1:0] vs_pipe;

  assign text_sel  = (mode_i == MODE_TEXT);
  assign attr_sel  = text_sel ? text_pix.attr : pln_pix.attr;
  assign mem_adr_o = text_sel ? text_pix.mem_adr : pln_pix.mem_adr;
  assign mem_stb_o = (text_sel ? text_pix.mem_stb : pln_pix.mem_stb) && video_on_v_i;

  // Undelayed row flag is fine, the 11 cycles fall in horizontal blanking
  assign v_retrace_o  = !video_on_v_i;
  assign vh_retrace_o = v_retrace_o || !on_pipe[2];
  assign vsync_o      = vs_pipe[VS_DELAY-1];

  always_ff @(posedge clk)
  begin
    if (pal_we_i)
      palette[pal_addr_i] <= pal_dat_i;
    if (dac_we_i)
      dac[dac_addr_i] <= dac_dat_i;
    pal_idx <= palette[attr_sel];
    dac_q   <= dac[pal_idx];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      on_pipe <= 3'b000;
      hs_pipe <= 2'b11;
      vs_pipe <= '1;
      hsync_o <= 1'b1;
      red_o   <= 4'h0;
      green_o <= 4'h0;
      blue_o  <= 4'h0;
    end
    else
    begin
      on_pipe <= {on_pipe[1:0], text_sel ? text_pix.video_on : pln_pix.video_on};
      hs_pipe <= {hs_pipe[0], text_sel ? text_pix.hsync_n : pln_pix.hsync_n};
      vs_pipe <= {vs_pipe[VS_DELAY-2:0], vsync_n_i};
      hsync_o <= hs_pipe[1];
      red_o   <= (on_pipe[1] && video_on_v_i) ? dac_q.red[5:2]   : 4'h0;
      green_o <= (on_pipe[1] && video_on_v_i) ? dac_q.green[5:2] : 4'h0;
      blue_o  <= (on_pipe[1] && video_on_v_i) ? dac_q.blue[5:2]  : 4'h0;
    end
  end

endmodule

/* source/crt_timing.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

module crt_timing (
  input  logic                   clk,
  input  logic                   rst,
  input  vga_pkg::display_mode_e mode_i,
  output logic                   vsync_n_o,
  scan_if.timing                 scan
);
  import vga_pkg::*;

  logic [9:0] h_next;
  logic [9:0] v_next;
  logic [9:0] v_disp_end;
  logic [9:0] v_sync_beg;
  logic [9:0] v_sync_end;
  logic [9:0] v_scan_end;

  assign v_disp_end = (mode_i == MODE_PLANAR) ? `PLN_DISP_END : `TXT_DISP_END;
  assign v_sync_beg = (mode_i == MODE_PLANAR) ? `PLN_SYNC_BEG : `TXT_SYNC_BEG;
  assign v_sync_end = (mode_i == MODE_PLANAR) ? `PLN_SYNC_END : `TXT_SYNC_END;
  assign v_scan_end = (mode_i == MODE_PLANAR) ? `PLN_SCAN_END : `TXT_SCAN_END;

  assign h_next = (scan.h_count == `HOR_SCAN_END) ? 10'd0 : scan.h_count + 10'd1;

  // A mode switch mid-frame may leave v_count beyond the new end
  always_comb
  begin
    v_next = scan.v_count;
    if (scan.h_count == `HOR_SCAN_END)
      v_next = (scan.v_count >= v_scan_end) ? 10'd0 : scan.v_count + 10'd1;
  end

  // Flags come from the next count so they line up with the counters
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      scan.h_count    <= 10'd0;
      scan.v_count    <= 10'd0;
      scan.hsync_n    <= 1'b1;
      scan.video_on_h <= 1'b1;  // h_count 0 is visible
      scan.video_on_v <= 1'b0;  // No fetches while in reset
      vsync_n_o       <= 1'b1;
    end
    else
    begin
      scan.h_count    <= h_next;
      scan.v_count    <= v_next;
      scan.hsync_n    <= !((h_next > `HOR_SYNC_BEG) && (h_next <= `HOR_SYNC_END));
      scan.video_on_h <= (h_next <= `HOR_DISP_END);
      scan.video_on_v <= (v_next < v_disp_end);
      vsync_n_o       <= !((v_next >= v_sync_beg) && (v_next < v_sync_end));
    end
  end

  h_in_range: assert property (@(posedge clk) disable iff (rst)
    scan.h_count <= `HOR_SCAN_END);

endmodule

/* source/pixel_if.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

interface pixel_if;
  import vga_pkg::*;

  attr_t                 attr;
  logic                  video_on;   // video_on_h after the render delay
  logic                  hsync_n;
  logic [`MEM_ADR_W-1:0] mem_adr;
  logic                  mem_stb;

  modport render (
    output attr, video_on, hsync_n, mem_adr, mem_stb
  );

  modport mixer (
    input attr, video_on, hsync_n, mem_adr, mem_stb
  );
endinterface

/* source/planar_renderer.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

module planar_renderer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MEM_DAT_W-1:0] mem_dat_i,
  scan_if.render                scan,
  pixel_if.render               pix
);
  import vga_pkg::*;

  localparam int AW = `MEM_ADR_W;

  logic                     stb_d;
  logic [15:0]              word_q;
  logic [15:0]              hold_q;
  logic [15:0]              shift_q;
  logic [`RENDER_DELAY-1:0] on_pipe;
  logic [`RENDER_DELAY-1:0] hs_pipe;

  // One word per 4 pixels, 160 words per row
  assign pix.mem_stb  = (scan.h_count[1:0] == 2'd0) && (scan.h_count <= `HOR_DISP_END);
  assign pix.mem_adr  = AW'(scan.v_count) * AW'(160) + AW'(scan.h_count[9:2]);
  assign pix.video_on = on_pipe[`RENDER_DELAY-1];
  assign pix.hsync_n  = hs_pipe[`RENDER_DELAY-1];

  always_ff @(posedge clk)
  begin
    if (stb_d)
      word_q <= mem_dat_i;
    if (scan.h_count[1:0] == 2'd3)
      hold_q <= word_q;  // Hold stage
    if (scan.h_count[1:0] == 2'd2)
      shift_q <= hold_q;
    else
      shift_q <= {shift_q[11:0], 4'h0};
    pix.attr <= shift_q[15:12];  // Pixel 0 in the top nibble
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stb_d   <= 1'b0;
      on_pipe <= '0;
      hs_pipe <= '1;
    end
    else
    begin
      stb_d   <= pix.mem_stb;
      on_pipe <= {on_pipe[`RENDER_DELAY-2:0], scan.video_on_h};
      hs_pipe <= {hs_pipe[`RENDER_DELAY-2:0], scan.hsync_n};
    end
  end

endmodule

/* source/scan_if.sv */
`timescale 1ns/1ps

interface scan_if;
  logic [9:0] h_count;
  logic [9:0] v_count;
  logic       hsync_n;
  logic       video_on_h;
  logic       video_on_v;

  // Flags are aligned with the counters on every cycle
  modport timing (
    output h_count, v_count, hsync_n, video_on_h, video_on_v
  );

  modport render (
    input h_count, v_count, hsync_n, video_on_h, video_on_v
  );
endinterface

/* source/text_renderer.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

module text_renderer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MEM_DAT_W-1:0] mem_dat_i,
  scan_if.render                scan,
  pixel_if.render               pix
);
  import vga_pkg::*;

  localparam int AW = `MEM_ADR_W;

  fetch_state_e             state;
  logic                     char_stb;
  logic [AW-1:0]            char_adr;
  logic [AW-1:0]            font_adr;
  logic [7:0]               char_attr;
  logic [7:0]               font_q;
  logic [7:0]               attr_q;
  logic [7:0]               shift_font;
  logic [7:0]               shift_attr;
  attr_t                    pix_attr;
  logic [`RENDER_DELAY-1:0] on_pipe;
  logic [`RENDER_DELAY-1:0] hs_pipe;

  // Group of 8 pixels starts at offset 0
  assign char_stb = (state == FETCH_IDLE) && (scan.h_count[2:0] == 3'd0)
                    && (scan.h_count <= `HOR_DISP_END);

  assign char_adr = `TEXT_BASE + AW'(scan.v_count[9:4]) * AW'(80) + AW'(scan.h_count[9:3]);
  assign font_adr = `FONT_BASE + AW'({mem_dat_i[7:0], scan.v_count[3:0]});  // Code just read

  assign pix.mem_stb  = char_stb || (state == FETCH_CHAR);
  assign pix.mem_adr  = (state == FETCH_CHAR) ? font_adr : char_adr;
  assign pix.attr     = pix_attr;
  assign pix.video_on = on_pipe[`RENDER_DELAY-1];
  assign pix.hsync_n  = hs_pipe[`RENDER_DELAY-1];

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= FETCH_IDLE;
    else
      case (state)
        FETCH_IDLE: if (char_stb) state <= FETCH_CHAR;
        FETCH_CHAR: state <= FETCH_FONT;
        default:    state <= FETCH_IDLE;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == FETCH_CHAR)
      char_attr <= mem_dat_i[15:8];
    if (state == FETCH_FONT)
    begin
      font_q <= mem_dat_i[7:0];
      attr_q <= char_attr;
    end
    // Offset 6 is the group start once the output register is counted
    if (scan.h_count[2:0] == 3'd6)
    begin
      shift_font <= font_q;
      shift_attr <= attr_q;
    end
    else
      shift_font <= {shift_font[6:0], 1'b0};
    pix_attr <= shift_font[7] ? shift_attr[3:0] : shift_attr[7:4];  // Fg when set
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      on_pipe <= '0;
      hs_pipe <= '1;
    end
    else
    begin
      on_pipe <= {on_pipe[`RENDER_DELAY-2:0], scan.video_on_h};
      hs_pipe <= {hs_pipe[`RENDER_DELAY-2:0], scan.hsync_n};
    end
  end

  stb_in_line: assert property (@(posedge clk) disable iff (rst)
    pix.mem_stb |-> scan.video_on_h);

endmodule

/* source/vga_pkg.sv */
package vga_pkg;

  // Also picks vertical timing and memory port owner
  typedef enum logic {
    MODE_TEXT   = 1'b0,
    MODE_PLANAR = 1'b1
  } display_mode_e;

  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_CHAR = 2'd1,  // Character word on the bus
    FETCH_FONT = 2'd2   // Font word on the bus
  } fetch_state_e;

  typedef logic [3:0] attr_t;

  typedef struct packed {
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;
  } rgb18_t;

endpackage

/* source/vga_top.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_top (
  input  logic                   clk,
  input  logic                   rst,
  input  vga_pkg::display_mode_e mode_i,
  output logic [`MEM_ADR_W-1:0]  mem_adr_o,
  output logic                   mem_stb_o,
  input  logic [`MEM_DAT_W-1:0]  mem_dat_i,
  input  logic                   pal_we_i,
  input  logic [3:0]             pal_addr_i,
  input  logic [7:0]             pal_dat_i,
  input  logic                   dac_we_i,
  input  logic [7:0]             dac_addr_i,
  input  vga_pkg::rgb18_t        dac_dat_i,
  output logic [3:0]             red_o,
  output logic [3:0]             green_o,
  output logic [3:0]             blue_o,
  output logic                   hsync_o,
  output logic                   vsync_o,
  output logic                   v_retrace_o,
  output logic                   vh_retrace_o
);
  logic vsync_n;  // Scan-aligned, delayed in the mixer

  scan_if  scan ();
  pixel_if text_pix ();
  pixel_if pln_pix ();

  crt_timing u_timing (
    .clk(clk), .rst(rst), .mode_i(mode_i), .vsync_n_o(vsync_n), .scan(scan.timing)
  );

  text_renderer u_text (
    .clk(clk), .rst(rst), .mem_dat_i(mem_dat_i), .scan(scan.render), .pix(text_pix.render)
  );

  planar_renderer u_planar (
    .clk(clk), .rst(rst), .mem_dat_i(mem_dat_i), .scan(scan.render), .pix(pln_pix.render)
  );

  color_mixer u_mixer (
    .clk(clk), .rst(rst), .mode_i(mode_i),
    .video_on_v_i(scan.video_on_v), .vsync_n_i(vsync_n),
    .text_pix(text_pix.mixer), .pln_pix(pln_pix.mixer),
    .pal_we_i(pal_we_i), .pal_addr_i(pal_addr_i), .pal_dat_i(pal_dat_i),
    .dac_we_i(dac_we_i), .dac_addr_i(dac_addr_i), .dac_dat_i(dac_dat_i),
    .mem_adr_o(mem_adr_o), .mem_stb_o(mem_stb_o),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o),
    .v_retrace_o(v_retrace_o), .vh_retrace_o(vh_retrace_o)
  );

endmodule

/* tb/vga_input.txt */
// cmd a b c : 0 mode m, 1 palette addr data, 2 dac addr data, 3 probe x y rgb, 4 scan frame, 7 end
// All fields hex, probe rgb is {red, green, blue} with 4 bits each
1 0 00 0
1 1 21 0
1 2 42 0
1 3 63 0
1 7 87 0
1 c c0 0
1 d d5 0
1 e ee 0
2 00 00000 0
2 21 3f000 0
2 42 00fc0 0
2 63 0003f 0
2 87 20408 0
2 c0 3cf3c 0
2 d5 14a3c 0
2 ee 0cc18 0
0 0 0 0
3 0 0 000
3 90 0 f00
3 91 0 000
3 198 30 0f0
3 19c 30 f00
3 19b 31 0f0
3 27f 18f fff
4 0 0 0
1 1 87 0
3 0 0 000
3 90 0 842
3 91 0 000
3 198 30 0f0
3 19c 30 842
4 0 0 0
0 1 0 0
3 0 0 000
3 7 0 00f
3 5 0 000
3 2 1 3c6
3 27f 1df 5af
3 64 c8 842
4 0 0 0
7 0 0 0

/* tb/vga_tb.sv */
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_tb;
  import vga_pkg::*;

  localparam int FRAME_CYCLES = 800 * 525;

  logic                  clk;
  logic                  rst;
  display_mode_e         mode_i;
  logic [`MEM_ADR_W-1:0] mem_adr_o;
  logic                  mem_stb_o;
  logic [`MEM_DAT_W-1:0] mem_dat_i;
  logic                  pal_we_i;
  logic [3:0]            pal_addr_i;
  logic [7:0]            pal_dat_i;
  logic                  dac_we_i;
  logic [7:0]            dac_addr_i;
  rgb18_t                dac_dat_i;
  logic [3:0]            red_o;
  logic [3:0]            green_o;
  logic [3:0]            blue_o;
  logic                  hsync_o;
  logic                  vsync_o;
  logic                  v_retrace_o;
  logic                  vh_retrace_o;

  logic [19:0] cmds [0:255];
  int          probe_x[$];
  int          probe_y[$];
  logic [11:0] probe_rgb[$];
  int          probe_hit[$];
  longint      cycles = 0;
  longint      limit = 64'd2000000000;
  int          i;
  int          n_frames;

  vga_top dut (
    .clk(clk), .rst(rst), .mode_i(mode_i),
    .mem_adr_o(mem_adr_o), .mem_stb_o(mem_stb_o), .mem_dat_i(mem_dat_i),
    .pal_we_i(pal_we_i), .pal_addr_i(pal_addr_i), .pal_dat_i(pal_dat_i),
    .dac_we_i(dac_we_i), .dac_addr_i(dac_addr_i), .dac_dat_i(dac_dat_i),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o),
    .v_retrace_o(v_retrace_o), .vh_retrace_o(vh_retrace_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory contents as a fixed function of address and mode
  function automatic logic [15:0] mem_word(int adr, display_mode_e mode);
    int prod;
    begin
      if (mode == MODE_PLANAR)
      begin
        prod = adr * 3;
        return prod[15:0];
      end
      if (adr < 4096)
        return {adr[11:4], adr[7:0]};  // Attribute, character
      prod = adr * 37;
      return {8'h00, prod[7:0]};  // Font byte
    end
  endfunction

  always @(posedge clk)
  begin
    if (mem_stb_o)
      mem_dat_i <= mem_word(int'(mem_adr_o), mode_i);
  end

  initial
  begin
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $fatal(1);
  end

  task automatic fail_run(string msg);
    begin
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic compare_rgb(string name, logic [11:0] got, logic [11:0] exp);
    begin
      if (got !== exp)
      begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  task automatic compare_sync(string name, logic got, logic exp);
    begin
      if (got !== exp)
      begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  task automatic compare_count(string name, logic [9:0] got, logic [9:0] exp);
    begin
      if (got !== exp)
      begin
        $display("Fail %s: got %h expected %h", name, got, exp);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  endtask

  task automatic check_idle_outputs;
    begin
      compare_sync("hsync_o", hsync_o, 1'b1);
      compare_sync("vsync_o", vsync_o, 1'b1);
      compare_sync("mem_stb_o", mem_stb_o, 1'b0);
      compare_rgb("rgb", {red_o, green_o, blue_o}, 12'h000);
    end
  endtask

  task automatic wait_vsync_fall;
    logic prev;
    begin
      prev = vsync_o;
      @(negedge clk);
      while (!(prev && !vsync_o))
      begin
        prev = vsync_o;
        @(negedge clk);
      end
    end
  endtask

  // One frame from vsync fall to vsync fall; row tracks the line shown after each hsync rise
  task automatic scan_frame;
    int   pos;
    int   row;
    int   row_next;
    int   total;
    int   disp_end;
    int   vs_lines;
    int   lines;
    int   vlines;
    int   low_cnt;
    int   x;
    int   k;
    bit   have_rise;
    bit   done;
    logic prev_hs;
    logic prev_vs;
    begin
      total    = (mode_i == MODE_PLANAR) ? 525 : 449;
      disp_end = (mode_i == MODE_PLANAR) ? 480 : 400;
      vs_lines = (mode_i == MODE_PLANAR) ? 2 : 3;
      row_next = (mode_i == MODE_PLANAR) ? 491 : 413;  // Line after sync begin
      row = 0;
      pos = 0;
      lines = 0;
      vlines = 0;
      low_cnt = 0;
      have_rise = 0;
      done = 0;
      wait_vsync_fall();
      prev_hs = hsync_o;
      prev_vs = vsync_o;
      while (!done)
      begin
        @(negedge clk);
        if (prev_vs && !vsync_o)
          done = 1;
        else
        begin
          if (!prev_hs && hsync_o)
          begin
            if (have_rise)
              compare_count("hsync period", 10'(pos + 1), 10'd800);
            compare_count("hsync low width", 10'(low_cnt), 10'd96);
            low_cnt = 0;
            pos = 0;
            have_rise = 1;
            row = row_next;
            row_next = (row_next + 1) % total;
            lines++;
            if (!vsync_o)
              vlines++;
          end
          else
            pos++;
          if (!hsync_o)
            low_cnt++;
          x = pos - 48;
          if (have_rise)
          begin
            if (x < 0 || x > 639)
            begin
              compare_sync("vh_retrace_o", vh_retrace_o, 1'b1);
              compare_rgb("blank rgb", {red_o, green_o, blue_o}, 12'h000);
            end
            else if (row >= disp_end)
            begin
              compare_sync("v_retrace_o", v_retrace_o, 1'b1);
              compare_sync("vh_retrace_o", vh_retrace_o, 1'b1);
              compare_rgb("blank rgb", {red_o, green_o, blue_o}, 12'h000);
            end
            else
            begin
              compare_sync("v_retrace_o", v_retrace_o, 1'b0);
              compare_sync("vh_retrace_o", vh_retrace_o, 1'b0);
              for (k = 0; k < probe_x.size(); k++)
                if (probe_x[k] == x && probe_y[k] == row)
                begin
                  compare_rgb("probe rgb", {red_o, green_o, blue_o}, probe_rgb[k]);
                  probe_hit[k]++;
                end
            end
          end
        end
        prev_hs = hsync_o;
        prev_vs = vsync_o;
      end
      compare_count("lines per frame", 10'(lines), 10'(total));
      compare_count("vsync low lines", 10'(vlines), 10'(vs_lines));
      for (k = 0; k < probe_hit.size(); k++)
        if (probe_hit[k] == 0)
          fail_run("A probe position was never reached during the frame");
      probe_x.delete();
      probe_y.delete();
      probe_rgb.delete();
      probe_hit.delete();
    end
  endtask

  initial
  begin
    rst        = 1'b1;
    mode_i     = MODE_TEXT;
    mem_dat_i  = '0;
    pal_we_i   = 1'b0;
    pal_addr_i = 4'h0;
    pal_dat_i  = 8'h00;
    dac_we_i   = 1'b0;
    dac_addr_i = 8'h00;
    dac_dat_i  = '0;
    $readmemh("tb/vga_input.txt", cmds);

    // Each mode change and frame scan may take up to two frames
    n_frames = 2;
    for (i = 0; i < 256; i += 4)
      if (cmds[i] == 20'd0 || cmds[i] == 20'd4)
        n_frames += 2;
    limit = longint'(n_frames) * FRAME_CYCLES + 10000;

    repeat (3)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle_outputs();  // Just out of reset

    i = 0;
    while (cmds[i] !== 20'd7)
    begin
      if (i > 251)
        fail_run("The input file has no end command");
      case (cmds[i])
        20'd0:
        begin
          @(posedge clk);
          mode_i <= display_mode_e'(cmds[i+1][0]);
          wait_vsync_fall();  // Let the new timing settle
        end
        20'd1:
        begin
          @(posedge clk);
          pal_we_i   <= 1'b1;
          pal_addr_i <= cmds[i+1][3:0];
          pal_dat_i  <= cmds[i+2][7:0];
          @(posedge clk);
          pal_we_i   <= 1'b0;
        end
        20'd2:
        begin
          @(posedge clk);
          dac_we_i   <= 1'b1;
          dac_addr_i <= cmds[i+1][7:0];
          dac_dat_i  <= rgb18_t'(cmds[i+2][17:0]);
          @(posedge clk);
          dac_we_i   <= 1'b0;
        end
        20'd3:
        begin
          probe_x.push_back(int'(cmds[i+1]));
          probe_y.push_back(int'(cmds[i+2]));
          probe_rgb.push_back(cmds[i+3][11:0]);
          probe_hit.push_back(0);
        end
        20'd4:
          scan_frame();
        default:
          fail_run("Unknown command in the input file");
      endcase
      i += 4;
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
source/vga_pkg.sv
source/scan_if.sv
source/pixel_if.sv
source/crt_timing.sv
source/text_renderer.sv
source/planar_renderer.sv
source/color_mixer.sv
source/vga_top.sv
tb/vga_tb.sv
